// ==== Bender.yml ====
package:
  name: hyper_ctrl

sources:
  - source/hyper_pkg.sv
  - source/hyper_ca_gen.sv
  - source/hyper_fsm.sv
  - source/hyper_dq_path.sv
  - source/hyper_ctrl_top.sv
  - target: test
    files:
      - testbench/tb_hyper_mem.sv
      - testbench/tb_hyper_ctrl.sv

// ==== project.f ====
source/hyper_pkg.sv
source/hyper_ca_gen.sv
source/hyper_fsm.sv
source/hyper_dq_path.sv
source/hyper_ctrl_top.sv
testbench/tb_hyper_mem.sv
testbench/tb_hyper_ctrl.sv

// ==== source/hyper_ca_gen.sv ====
// request fields must be stable until accepted; the address space bit is always zero
`timescale 1ns/1ps

module hyper_ca_gen (
    input  logic                               clk0,
    input  logic                               rst_ni,
    input  logic                               accept_i,
    input  logic [31:0]                        trans_address_i,
    input  logic [hyper_pkg::NR_CS-1:0]        trans_cs_i,
    input  logic                               trans_write_i,
    input  logic                               trans_burst_type_i,
    input  logic [hyper_pkg::BURST_WIDTH-1:0]  trans_burst_i,
    input  logic [hyper_pkg::CA_SEL_WIDTH-1:0] ca_sel_i,
    output logic [hyper_pkg::WORD_WIDTH-1:0]   ca_word_o,
    output logic [hyper_pkg::NR_CS-1:0]        cs_o,
    output logic                               write_o,
    output logic [hyper_pkg::BURST_WIDTH-1:0]  burst_o
);
    import hyper_pkg::*;

    logic [31:0]         addr_q;
    logic                burst_type_q;
    hyper_rw_e           rw;
    logic [CA_WIDTH-1:0] ca;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            cs_o    <= '0;
            write_o <= 1'b0;
        end else if (accept_i) begin
            cs_o    <= trans_cs_i;
            write_o <= trans_write_i;
        end
    end

    // transaction copy
    always_ff @(posedge clk0) begin
        if (accept_i) begin
            addr_q       <= trans_address_i;
            burst_type_q <= trans_burst_type_i;
            burst_o      <= trans_burst_i;
        end
    end

    assign rw = write_o ? HYPER_WRITE : HYPER_READ;

    // cmd, space, burst type, upper address, reserved, lower address
    assign ca = {rw, 1'b0, burst_type_q, addr_q[31:3], 13'b0, addr_q[2:0]};

    // word 0 is the top of the CA word
    assign ca_word_o = ca[CA_WIDTH - 1 - WORD_WIDTH * ca_sel_i -: WORD_WIDTH];

    // index comes from the fsm
    assert property (@(posedge clk0) disable iff (!rst_ni)
        ca_sel_i < CA_SEL_WIDTH'(CA_WORDS));

endmodule

// ==== source/hyper_ctrl_top.sv ====
// timing inputs held constant per transaction; clock, DDR cells and RWDS delay not modelled
`timescale 1ns/1ps

module hyper_ctrl_top (
    input  logic                              clk0,
    input  logic                              rst_ni,
    input  logic [hyper_pkg::CFG_WIDTH-1:0]   cfg_lat_access_i,
    input  logic [hyper_pkg::CFG_WIDTH-1:0]   cfg_lat_additional_i,
    input  logic [hyper_pkg::CFG_WIDTH-1:0]   cfg_rwr_i,
    input  logic [hyper_pkg::CFG_WIDTH-1:0]   cfg_cs_max_i,
    input  logic                              trans_valid_i,
    output logic                              trans_ready_o,
    input  logic [31:0]                       trans_address_i,
    input  logic [hyper_pkg::NR_CS-1:0]       trans_cs_i,
    input  logic                              trans_write_i,
    input  logic [hyper_pkg::BURST_WIDTH-1:0] trans_burst_i,
    input  logic                              trans_burst_type_i,
    input  logic                              tx_valid_i,
    output logic                              tx_ready_o,
    input  logic [hyper_pkg::WORD_WIDTH-1:0]  tx_data_i,
    input  logic [hyper_pkg::STRB_WIDTH-1:0]  tx_strb_i,
    output logic                              rx_valid_o,
    output logic [hyper_pkg::WORD_WIDTH-1:0]  rx_data_o,
    output logic                              rx_last_o,
    output logic                              rx_error_o,
    output logic                              b_valid_o,
    output logic                              b_error_o,
    output logic [hyper_pkg::NR_CS-1:0]       hyper_cs_no,
    output logic                              hyper_ck_en_o,
    input  logic [hyper_pkg::WORD_WIDTH-1:0]  hyper_dq_i,
    output logic [hyper_pkg::WORD_WIDTH-1:0]  hyper_dq_o,
    output logic                              hyper_dq_oe_o,
    input  logic                              hyper_rwds_i,
    output logic [hyper_pkg::STRB_WIDTH-1:0]  hyper_rwds_o,
    output logic                              hyper_rwds_oe_o
);
    import hyper_pkg::*;

    logic                    accept;
    logic [CA_SEL_WIDTH-1:0] ca_sel;
    logic [WORD_WIDTH-1:0]   ca_word;
    logic [NR_CS-1:0]        cs;
    logic                    cs_en;
    logic                    write;
    logic [BURST_WIDTH-1:0]  burst;
    logic                    ca_phase;
    logic                    data_w;
    logic                    rd_en;
    logic                    rd_last;
    logic                    error;
    logic                    tx_fire;

    assign tx_fire     = tx_valid_i & tx_ready_o;
    assign hyper_cs_no = ~(cs & {NR_CS{cs_en}});

    hyper_ca_gen u_ca_gen (
        .clk0               (clk0),
        .rst_ni             (rst_ni),
        .accept_i           (accept),
        .trans_address_i    (trans_address_i),
        .trans_cs_i         (trans_cs_i),
        .trans_write_i      (trans_write_i),
        .trans_burst_type_i (trans_burst_type_i),
        .trans_burst_i      (trans_burst_i),
        .ca_sel_i           (ca_sel),
        .ca_word_o          (ca_word),
        .cs_o               (cs),
        .write_o            (write),
        .burst_o            (burst)
    );

    hyper_fsm u_fsm (
        .clk0                 (clk0),
        .rst_ni               (rst_ni),
        .trans_valid_i        (trans_valid_i),
        .trans_ready_o        (trans_ready_o),
        .accept_o             (accept),
        .write_i              (write),
        .burst_i              (burst),
        .cfg_lat_access_i     (cfg_lat_access_i),
        .cfg_lat_additional_i (cfg_lat_additional_i),
        .cfg_rwr_i            (cfg_rwr_i),
        .cfg_cs_max_i         (cfg_cs_max_i),
        .hyper_rwds_i         (hyper_rwds_i),
        .tx_valid_i           (tx_valid_i),
        .tx_ready_o           (tx_ready_o),
        .ca_sel_o             (ca_sel),
        .ca_phase_o           (ca_phase),
        .data_w_o             (data_w),
        .cs_en_o              (cs_en),
        .ck_en_o              (hyper_ck_en_o),
        .rd_en_o              (rd_en),
        .rd_last_o            (rd_last),
        .error_o              (error),
        .b_valid_o            (b_valid_o),
        .b_error_o            (b_error_o)
    );

    hyper_dq_path u_dq_path (
        .clk0            (clk0),
        .rst_ni          (rst_ni),
        .ca_word_i       (ca_word),
        .ca_phase_i      (ca_phase),
        .data_w_i        (data_w),
        .tx_fire_i       (tx_fire),
        .tx_data_i       (tx_data_i),
        .tx_strb_i       (tx_strb_i),
        .rd_en_i         (rd_en),
        .rd_last_i       (rd_last),
        .error_i         (error),
        .hyper_rwds_i    (hyper_rwds_i),
        .hyper_dq_i      (hyper_dq_i),
        .hyper_dq_o      (hyper_dq_o),
        .hyper_dq_oe_o   (hyper_dq_oe_o),
        .hyper_rwds_o    (hyper_rwds_o),
        .hyper_rwds_oe_o (hyper_rwds_oe_o),
        .rx_valid_o      (rx_valid_o),
        .rx_last_o       (rx_last_o),
        .rx_error_o      (rx_error_o),
        .rx_data_o       (rx_data_o)
    );

endmodule

// ==== source/hyper_dq_path.sv ====
// no rx back-pressure; rx words and the timeout pulse appear two cycles after capture
`timescale 1ns/1ps

module hyper_dq_path (
    input  logic                             clk0,
    input  logic                             rst_ni,
    input  logic [hyper_pkg::WORD_WIDTH-1:0] ca_word_i,
    input  logic                             ca_phase_i,
    input  logic                             data_w_i,
    input  logic                             tx_fire_i,
    input  logic [hyper_pkg::WORD_WIDTH-1:0] tx_data_i,
    input  logic [hyper_pkg::STRB_WIDTH-1:0] tx_strb_i,
    input  logic                             rd_en_i,
    input  logic                             rd_last_i,
    input  logic                             error_i,
    input  logic                             hyper_rwds_i,
    input  logic [hyper_pkg::WORD_WIDTH-1:0] hyper_dq_i,
    output logic [hyper_pkg::WORD_WIDTH-1:0] hyper_dq_o,
    output logic                             hyper_dq_oe_o,
    output logic [hyper_pkg::STRB_WIDTH-1:0] hyper_rwds_o,
    output logic                             hyper_rwds_oe_o,
    output logic                             rx_valid_o,
    output logic                             rx_last_o,
    output logic                             rx_error_o,
    output logic [hyper_pkg::WORD_WIDTH-1:0] rx_data_o
);
    import hyper_pkg::*;

    logic [WORD_WIDTH-1:0] wdata_q;
    logic [STRB_WIDTH-1:0] wstrb_q;
    logic                  ca_phase_q;
    logic                  data_w_q;
    logic [WORD_WIDTH-1:0] rd_data_q;
    logic                  rd_valid_q;
    logic                  rd_last_q;
    logic                  rd_error_q;
    logic                  rd_fire;

    always_ff @(posedge clk0) begin
        if (tx_fire_i) begin
            wdata_q <= tx_data_i;
            wstrb_q <= tx_strb_i;
        end
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            ca_phase_q <= 1'b0;
            data_w_q   <= 1'b0;
        end else begin
            ca_phase_q <= ca_phase_i;
            data_w_q   <= data_w_i;
        end
    end

    assign hyper_dq_o      = ca_phase_q ? ca_word_i : wdata_q;
    assign hyper_dq_oe_o   = ca_phase_q | data_w_q;
    assign hyper_rwds_o    = ~wstrb_q;  // rwds high masks the byte
    assign hyper_rwds_oe_o = data_w_q;

    // read capture, error travels behind any words in flight
    assign rd_fire = rd_en_i & hyper_rwds_i;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_valid_q <= 1'b0;
            rd_last_q  <= 1'b0;
            rd_error_q <= 1'b0;
            rx_valid_o <= 1'b0;
            rx_last_o  <= 1'b0;
            rx_error_o <= 1'b0;
        end else begin
            rd_valid_q <= rd_fire | error_i;
            rd_last_q  <= (rd_fire & rd_last_i) | error_i;
            rd_error_q <= error_i;
            rx_valid_o <= rd_valid_q;
            rx_last_o  <= rd_last_q;
            rx_error_o <= rd_error_q;
        end
    end

    always_ff @(posedge clk0) begin
        if (rd_fire) begin
            rd_data_q <= hyper_dq_i;
        end
        if (rd_valid_q) begin
            rx_data_o <= rd_data_q;
        end
    end

endmodule

// ==== source/hyper_fsm.sv ====
// cfg_lat_access_i, cfg_rwr_i and bursts must be at least 1; cfg_cs_max_i of 0 means 65536
`timescale 1ns/1ps

module hyper_fsm (
    input  logic                               clk0,
    input  logic                               rst_ni,
    input  logic                               trans_valid_i,
    output logic                               trans_ready_o,
    output logic                               accept_o,
    input  logic                               write_i,
    input  logic [hyper_pkg::BURST_WIDTH-1:0]  burst_i,
    input  logic [hyper_pkg::CFG_WIDTH-1:0]    cfg_lat_access_i,
    input  logic [hyper_pkg::CFG_WIDTH-1:0]    cfg_lat_additional_i,
    input  logic [hyper_pkg::CFG_WIDTH-1:0]    cfg_rwr_i,
    input  logic [hyper_pkg::CFG_WIDTH-1:0]    cfg_cs_max_i,
    input  logic                               hyper_rwds_i,
    input  logic                               tx_valid_i,
    output logic                               tx_ready_o,
    output logic [hyper_pkg::CA_SEL_WIDTH-1:0] ca_sel_o,
    output logic                               ca_phase_o,
    output logic                               data_w_o,
    output logic                               cs_en_o,
    output logic                               ck_en_o,
    output logic                               rd_en_o,
    output logic                               rd_last_o,
    output logic                               error_o,
    output logic                               b_valid_o,
    output logic                               b_error_o
);
    import hyper_pkg::*;

    hyper_state_e            state_q;
    hyper_state_e            state_d;
    logic [CFG_WIDTH-1:0]    lat_cnt_q;  // also counts recovery
    logic [CFG_WIDTH-1:0]    lat_cnt_d;
    logic [BURST_WIDTH-1:0]  burst_cnt_q;
    logic [BURST_WIDTH-1:0]  burst_cnt_d;
    logic [CFG_WIDTH-1:0]    cs_cnt_q;
    logic [CA_SEL_WIDTH-1:0] ca_sel_q;
    logic                    wfire_q;
    logic                    tx_fire;
    logic                    timeout;

    assign trans_ready_o = state_q == IDLE;
    assign accept_o      = trans_valid_i & trans_ready_o;
    assign tx_ready_o    = (state_q == DATA_W && burst_cnt_q != '0) || state_q == WAIT_W;
    assign tx_fire       = tx_valid_i & tx_ready_o;
    assign cs_en_o       = state_q inside {CMD_ADDR, LATENCY, DATA_W, WAIT_W, DATA_R};
    assign timeout       = cs_en_o && cs_cnt_q == cfg_cs_max_i - 1'b1;

    always_comb begin
        state_d     = state_q;
        lat_cnt_d   = lat_cnt_q;
        burst_cnt_d = burst_cnt_q;
        case (state_q)
            IDLE: begin
                if (accept_o) begin
                    state_d = CMD_ADDR;
                end
            end
            CMD_ADDR: begin
                if (ca_sel_q == CA_SEL_WIDTH'(CA_WORDS - 1)) begin
                    // rwds high on word 2 asks for doubled latency
                    lat_cnt_d = hyper_rwds_i ? cfg_lat_access_i + cfg_lat_additional_i - 1'b1
                                             : cfg_lat_access_i - 1'b1;
                    state_d   = LATENCY;
                end
            end
            LATENCY: begin
                if (lat_cnt_q == '0) begin
                    burst_cnt_d = burst_i;
                    state_d     = write_i ? DATA_W : DATA_R;
                end else begin
                    lat_cnt_d = lat_cnt_q - 1'b1;
                end
            end
            DATA_W: begin
                if (burst_cnt_q == '0) begin  // last word on the bus
                    lat_cnt_d = cfg_rwr_i - 1'b1;
                    state_d   = RECOVER;
                end else if (tx_valid_i) begin
                    burst_cnt_d = burst_cnt_q - 1'b1;
                end else begin
                    state_d = WAIT_W;
                end
            end
            WAIT_W: begin
                if (tx_valid_i) begin
                    burst_cnt_d = burst_cnt_q - 1'b1;
                    state_d     = DATA_W;
                end
            end
            DATA_R: begin
                if (hyper_rwds_i) begin
                    burst_cnt_d = burst_cnt_q - 1'b1;
                    if (rd_last_o) begin
                        lat_cnt_d = cfg_rwr_i - 1'b1;
                        state_d   = RECOVER;
                    end
                end
            end
            ERROR: begin
                lat_cnt_d = cfg_rwr_i - 1'b1;
                state_d   = RECOVER;
            end
            RECOVER: begin
                if (lat_cnt_q == '0) begin
                    state_d = IDLE;
                end else begin
                    lat_cnt_d = lat_cnt_q - 1'b1;
                end
            end
            default: state_d = IDLE;
        endcase
        // a transaction finishing on time wins over the timeout
        if (timeout && state_d != RECOVER) begin
            state_d = ERROR;
        end
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= IDLE;
            lat_cnt_q   <= '0;
            burst_cnt_q <= '0;
            cs_cnt_q    <= '0;
            ca_sel_q    <= '0;
            wfire_q     <= 1'b0;
        end else begin
            state_q     <= state_d;
            lat_cnt_q   <= lat_cnt_d;
            burst_cnt_q <= burst_cnt_d;
            cs_cnt_q    <= cs_en_o ? cs_cnt_q + 1'b1 : '0;
            ca_sel_q    <= (state_q == CMD_ADDR && state_d == CMD_ADDR) ? ca_sel_q + 1'b1 : '0;
            wfire_q     <= tx_fire;  // word reaches the bus next cycle
        end
    end

    assign ca_sel_o   = ca_sel_q;
    assign ca_phase_o = state_d == CMD_ADDR;  // registered in the dq path
    assign data_w_o   = state_d inside {DATA_W, WAIT_W};
    assign ck_en_o    = state_q inside {CMD_ADDR, LATENCY, DATA_R} || wfire_q;
    assign rd_en_o    = state_q == DATA_R;
    assign rd_last_o  = burst_cnt_q == BURST_WIDTH'(1);
    assign error_o    = state_q == ERROR && !write_i;
    assign b_valid_o  = (state_q == DATA_W && burst_cnt_q == '0) || (state_q == ERROR && write_i);
    assign b_error_o  = state_q == ERROR && write_i;

    // bus quiet between transactions, including the last write beat
    assert property (@(posedge clk0) disable iff (!rst_ni)
        state_q inside {IDLE, RECOVER} |-> !cs_en_o && !ck_en_o);

    // write beats only for a write, and never past the burst
    assert property (@(posedge clk0) disable iff (!rst_ni)
        tx_ready_o |-> write_i && burst_cnt_q != '0);

endmodule

// ==== source/hyper_pkg.sv ====
// word-level HyperBus model: one 16-bit word per bus clock, memory space only
package hyper_pkg;

    localparam int WORD_WIDTH   = 16;
    localparam int STRB_WIDTH   = WORD_WIDTH / 8;  // one mask bit per byte
    localparam int CA_WIDTH     = 48;
    localparam int CA_WORDS     = CA_WIDTH / WORD_WIDTH;
    localparam int CA_SEL_WIDTH = 2;
    localparam int BURST_WIDTH  = 12;
    localparam int NR_CS        = 2;
    localparam int CFG_WIDTH    = 16;

    // transaction engine states
    typedef enum logic [3:0] {
        IDLE,
        CMD_ADDR,
        LATENCY,
        DATA_W,
        WAIT_W,
        DATA_R,
        ERROR,
        RECOVER
    } hyper_state_e;

    // CA bit 47
    typedef enum logic {
        HYPER_WRITE = 1'b0,
        HYPER_READ  = 1'b1
    } hyper_rw_e;

endpackage

// ==== testbench/tb_hyper_ctrl.sv ====
// random write/read pairs then a stalled read; memory addresses wrap at 256 words
`timescale 1ns/1ps

module tb_hyper_ctrl;
    import hyper_pkg::*;

    localparam int LAT         = 4;
    localparam int ADD         = 3;
    localparam int RWR         = 3;
    localparam int CS_MAX      = 1000;
    localparam int CS_MAX_TO   = 20;
    localparam int NR_PAIRS    = 12;
    localparam int TXN_WORST   = 3 + LAT + ADD + 3 * 8 + RWR + 4;  // gaps taken as 3x the burst
    localparam int CYCLE_LIMIT = 4 * (10 + (2 * NR_PAIRS + 2) * TXN_WORST + CS_MAX_TO);

    logic clk0, rst_ni, extra, stall;
    logic [CFG_WIDTH-1:0] cfg_lat_access_i, cfg_lat_additional_i, cfg_rwr_i, cfg_cs_max_i, mem_lat;
    logic trans_valid_i, trans_ready_o, trans_write_i, trans_burst_type_i;
    logic [31:0] trans_address_i;
    logic [NR_CS-1:0] trans_cs_i, hyper_cs_no;
    logic [BURST_WIDTH-1:0] trans_burst_i;
    logic tx_valid_i, tx_ready_o, rx_valid_o, rx_last_o, rx_error_o, b_valid_o, b_error_o;
    logic [WORD_WIDTH-1:0] tx_data_i, rx_data_o, hyper_dq_i, hyper_dq_o;
    logic [STRB_WIDTH-1:0] tx_strb_i, hyper_rwds_o;
    logic hyper_ck_en_o, hyper_dq_oe_o, hyper_rwds_i, hyper_rwds_oe_o;
    logic [47:0] ca_seen;
    logic [15:0] shadow [256];
    logic [17:0] exp_q [$];  // error, last, data
    integer seed = 92;
    int cycles = 0, b_count = 0, low_run = 0, high_run = 0, last_cs_run = 0;
    int ca_cnt = 0, lat_run = 0, lat_meas = 0;
    logic prev_low = 1'b0, seen_low = 1'b0, lat_done = 1'b0, gap_prev = 1'b0;

    assign mem_lat = extra ? LAT + ADD : LAT;

    hyper_ctrl_top u_hyper_ctrl_top (.*);

    tb_hyper_mem u_mem (
        .clk0 (clk0), .cs_ni (hyper_cs_no), .ck_en_i (hyper_ck_en_o), .dq_i (hyper_dq_o),
        .dq_oe_i (hyper_dq_oe_o), .mask_i (hyper_rwds_o), .rwds_oe_i (hyper_rwds_oe_o),
        .lat_i (mem_lat), .extra_i (extra), .stall_i (stall), .dq_o (hyper_dq_i),
        .rwds_o (hyper_rwds_i), .ca_o (ca_seen)
    );

    initial begin
        clk0 = 1'b0;
        forever #2 clk0 = ~clk0;
    end

    // CA word from the bit layout of the command/address phase
    function automatic logic [47:0] ca_ref(logic [31:0] addr, logic write, logic btype);
        return {!write, 1'b0, btype, addr[31:3], 13'b0, addr[2:0]};
    endfunction

    function automatic logic [15:0] exp_word(logic [31:0] addr);
        return shadow[addr[7:0]];
    endfunction

    task automatic fail_run();
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, logic [47:0] exp, logic [47:0] act);
        $display("ERR %s expected %h actual %h", name, exp, act);
        fail_run();
    endtask

    task automatic report_problem(string what);
        $display("%s", what);
        fail_run();
    endtask

    task automatic issue(logic [31:0] addr, int burst, logic write, logic btype);
        @(negedge clk0);
        trans_address_i    = addr;
        trans_burst_i      = burst;
        trans_write_i      = write;
        trans_burst_type_i = btype;
        trans_cs_i         = ($random(seed) & 1) ? 2'b01 : 2'b10;
        trans_valid_i      = 1'b1;
        b_count            = 0;
        @(posedge clk0);
        while (!trans_ready_o) @(posedge clk0);
        @(negedge clk0);
        trans_valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        @(posedge clk0);
        while (!trans_ready_o) @(posedge clk0);
        while (exp_q.size() != 0) @(posedge clk0);
    endtask

    task automatic run_write(logic [31:0] addr, int burst, logic btype, logic gaps);
        logic [31:0] a;
        int i;
        issue(addr, burst, 1'b1, btype);
        i = 0;
        while (i < burst) begin
            @(negedge clk0);
            tx_valid_i = !gaps || ($random(seed) % 3 != 0);
            tx_data_i  = $random(seed);
            tx_strb_i  = $random(seed);
            @(posedge clk0);
            if (tx_valid_i && tx_ready_o) begin
                a = addr + i;
                if (tx_strb_i[0]) shadow[a[7:0]][7:0] = tx_data_i[7:0];
                if (tx_strb_i[1]) shadow[a[7:0]][15:8] = tx_data_i[15:8];
                i++;
            end
        end
        @(negedge clk0);
        tx_valid_i = 1'b0;
        wait_idle();
        assert (b_count == 1) else report_mismatch("write_response_count", 1, b_count);
        assert (ca_seen == ca_ref(addr, 1'b1, btype))
            else report_mismatch("write_ca", ca_ref(addr, 1'b1, btype), ca_seen);
        assert (lat_meas == mem_lat) else report_mismatch("latency", mem_lat, lat_meas);
    endtask

    task automatic run_read(logic [31:0] addr, int burst, logic btype, logic timeout);
        if (timeout) begin
            exp_q.push_back(18'h30000);
        end else begin
            for (int i = 0; i < burst; i++) begin
                exp_q.push_back({1'b0, i == burst - 1, exp_word(addr + i)});
            end
        end
        issue(addr, burst, 1'b0, btype);
        wait_idle();
        assert (ca_seen == ca_ref(addr, 1'b0, btype))
            else report_mismatch("read_ca", ca_ref(addr, 1'b0, btype), ca_seen);
    endtask

    // compares every rx pulse with the next expected word
    always @(posedge clk0) begin
        logic [17:0] e;
        if (rst_ni && rx_valid_o) begin
            assert (exp_q.size() != 0)
                else report_problem("read word arrived with none expected");
            e = exp_q.pop_front();
            assert (rx_error_o == e[17]) else report_mismatch("rx_error", e[17], rx_error_o);
            assert (rx_last_o == e[16]) else report_mismatch("rx_last", e[16], rx_last_o);
            assert (e[17] || rx_data_o == e[15:0])
                else report_mismatch("rx_data", e[15:0], rx_data_o);
        end
    end

    // bus monitor: chip select runs, latency, write gaps, responses
    always @(posedge clk0) begin
        cycles++;
        assert (cycles < CYCLE_LIMIT)
            else report_problem("run exceeded its cycle limit, DUT stuck");
        if (rst_ni) begin
            if (hyper_cs_no == '1) begin
                if (prev_low) last_cs_run = low_run;
                // first ready cycle closes the recovery gap
                if (seen_low && trans_ready_o) begin
                    assert (high_run >= RWR)
                        else report_problem("chip select high for less than the recovery time");
                    seen_low = 1'b0;
                end
                high_run++;
                low_run  = 0;
                ca_cnt   = 0;
                lat_done = 1'b0;
                prev_low = 1'b0;
            end else begin
                assert (hyper_cs_no == ~trans_cs_i)
                    else report_mismatch("chip_select", NR_CS'(~trans_cs_i), hyper_cs_no);
                seen_low = 1'b1;
                prev_low = 1'b1;
                high_run = 0;
                low_run++;
                if (ca_cnt < 3) begin
                    ca_cnt += hyper_dq_oe_o;
                    lat_run = 0;
                end else if (!lat_done && tx_ready_o) begin
                    lat_meas = lat_run;
                    lat_done = 1'b1;
                end else begin
                    lat_run++;
                end
            end
            assert (!gap_prev || !hyper_ck_en_o)
                else report_problem("bus clock ran in a write gap");
            gap_prev = tx_ready_o && !tx_valid_i;
            if (b_valid_o) begin
                b_count++;
                assert (!b_error_o) else report_problem("write ended with an error response");
            end
        end
    end

    initial begin
        logic [31:0] addr;
        int burst;
        logic btype;
        for (int i = 0; i < 256; i++) shadow[i] = {i[7:0], 8'h5a ^ i[7:0]};
        rst_ni = 1'b0;
        {extra, stall} = 2'b00;
        cfg_lat_access_i = LAT;
        cfg_lat_additional_i = ADD;
        cfg_rwr_i = RWR;
        cfg_cs_max_i = CS_MAX;
        {trans_valid_i, trans_write_i, trans_burst_type_i, tx_valid_i} = '0;
        {trans_address_i, trans_cs_i, trans_burst_i, tx_data_i, tx_strb_i} = '0;
        repeat (10) @(posedge clk0);
        @(negedge clk0);
        rst_ni = 1'b1;
        for (int k = 0; k < NR_PAIRS; k++) begin
            addr  = $random(seed);
            burst = 1 + ($random(seed) & 7);
            btype = $random(seed);
            extra = $random(seed);
            run_write(addr, burst, btype, k[0]);
            extra = $random(seed);
            run_read(addr, burst, !btype, 1'b0);
        end
        // memory never strobes, chip select time runs out
        @(negedge clk0);
        cfg_cs_max_i = CS_MAX_TO;
        stall = 1'b1;
        run_read($random(seed), 4, 1'b1, 1'b1);
        assert (last_cs_run == CS_MAX_TO)
            else report_mismatch("cs_low_cycles", CS_MAX_TO, last_cs_run);
        @(negedge clk0);
        cfg_cs_max_i = CS_MAX;
        stall = 1'b0;
        run_read(32'h0000_0040, 3, 1'b1, 1'b0);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== testbench/tb_hyper_mem.sv ====
// word-level HyperRAM with 256 words; address bits above 7 wrap, total latency comes from lat_i
`timescale 1ns/1ps

module tb_hyper_mem (
    input  logic        clk0,
    input  logic [1:0]  cs_ni,
    input  logic        ck_en_i,
    input  logic [15:0] dq_i,
    input  logic        dq_oe_i,
    input  logic [1:0]  mask_i,
    input  logic        rwds_oe_i,
    input  logic [15:0] lat_i,
    input  logic        extra_i,  // ask for additional latency
    input  logic        stall_i,  // withhold read strobes
    output logic [15:0] dq_o,
    output logic        rwds_o,
    output logic [47:0] ca_o
);
    logic [15:0] mem [256];
    logic [31:0] addr;
    logic        rd;
    int          ca_cnt;
    int          wait_cnt;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], 8'h5a ^ i[7:0]};
        end
        dq_o   = '0;
        rwds_o = 1'b0;
        ca_cnt = 0;
        rd     = 1'b0;
    end

    // bus values are stable mid-cycle
    always @(negedge clk0) begin
        rwds_o <= 1'b0;
        if (cs_ni == '1) begin
            ca_cnt = 0;
        end else if (ca_cnt < 3) begin
            if (dq_oe_i) begin
                ca_o = {ca_o[31:0], dq_i};  // word 0 ends up on top
                ca_cnt++;
                if (ca_cnt == 3) begin
                    rwds_o   <= extra_i;
                    rd       = ca_o[47];
                    addr     = {ca_o[44:16], ca_o[2:0]};
                    wait_cnt = lat_i;
                end
            end
        end else if (!rd) begin
            if (ck_en_i && rwds_oe_i) begin
                if (!mask_i[0]) mem[addr[7:0]][7:0] = dq_i[7:0];
                if (!mask_i[1]) mem[addr[7:0]][15:8] = dq_i[15:8];
                addr++;
            end
        end else if (wait_cnt != 0) begin
            wait_cnt--;
        end else if (!stall_i) begin
            rwds_o <= 1'b1;
            dq_o   <= mem[addr[7:0]];
            addr++;
        end
    end

endmodule
